// File: bench/tb_rename_top.sv
`default_nettype none

`include "tomasulo_config.svh"

module tb_rename_top;

	localparam int DEPTH = `TOMA_ROB_DEPTH;
	localparam int TW = `TOMA_TAG_W;
	localparam int NREGS = `TOMA_NUM_REGS;
	localparam int RESET_CYCLES = 10;
	localparam int IDLE_CYCLES = 8;
	localparam int RANDOM_CYCLES = 900;
	// drain empties at most a full ROB, two cycles per entry is plenty
	localparam int DRAIN_BUDGET = 82;
	localparam int TIMEOUT_CYCLES = 4 * (RESET_CYCLES + IDLE_CYCLES + RANDOM_CYCLES + DRAIN_BUDGET);
	// small rd range so renames of the same register pile up
	localparam int RD_SPAN = 10;
	localparam int SRC_SPAN = 12;

	// one in-flight instruction in the scoreboard, oldest at index 0
	typedef struct packed {
		tomasulo_pkg::rob_tag_t tag;
		tomasulo_pkg::reg_idx_t rd;
		logic                   has_dest;
		logic                   ready;
		tomasulo_pkg::word_t    data;
	} model_entry_t;

	logic clk = 1'b0;
	logic rst = 1'b1;
	tomasulo_pkg::dispatch_t dispatch0 = '0;
	tomasulo_pkg::dispatch_t dispatch1 = '0;
	tomasulo_pkg::reg_idx_t rs1_0 = '0;
	tomasulo_pkg::reg_idx_t rs2_0 = '0;
	tomasulo_pkg::reg_idx_t rs1_1 = '0;
	tomasulo_pkg::reg_idx_t rs2_1 = '0;
	tomasulo_pkg::cdb_t cdb = '0;
	logic mispredict = 1'b0;
	tomasulo_pkg::rob_tag_t mispredict_tag = '0;

	logic dispatch_ready;
	tomasulo_pkg::rob_tag_t alloc_tag0;
	tomasulo_pkg::rob_tag_t alloc_tag1;
	tomasulo_pkg::src_read_t src0;
	tomasulo_pkg::src_read_t src1;
	tomasulo_pkg::commit_t commit;

	// scoreboard state
	model_entry_t rob_q [$];
	tomasulo_pkg::word_t arch_regs [NREGS];
	tomasulo_pkg::rob_tag_t model_rear = '0;

	// expected port values for the current cycle, reset state first
	logic exp_ready = 1'b1;
	tomasulo_pkg::rob_tag_t exp_tag0 = '0;
	tomasulo_pkg::rob_tag_t exp_tag1 = TW'(1);
	tomasulo_pkg::commit_t exp_commit = '0;
	tomasulo_pkg::src_read_t exp_src0 = '0;
	tomasulo_pkg::src_read_t exp_src1 = '0;
	// low in the cycle the regfile still rebuilds after a mispredict
	logic check_ops = 1'b1;

	logic [31:0] lcg_state = 32'd84762;
	int cycles = 0;
	string test_name = "reset";

	rename_top i_dut (
		.clk            (clk),
		.rst            (rst),
		.dispatch0      (dispatch0),
		.dispatch1      (dispatch1),
		.rs1_0          (rs1_0),
		.rs2_0          (rs2_0),
		.rs1_1          (rs1_1),
		.rs2_1          (rs2_1),
		.cdb            (cdb),
		.mispredict     (mispredict),
		.mispredict_tag (mispredict_tag),
		.dispatch_ready (dispatch_ready),
		.alloc_tag0     (alloc_tag0),
		.alloc_tag1     (alloc_tag1),
		.src0           (src0),
		.src1           (src1),
		.commit         (commit)
	);

	always #50 clk = ~clk;

	// run length guard
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TB FAILED");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	task automatic report_mismatch(input string what, input logic [127:0] expected,
		input logic [127:0] actual);
		$display("Mismatch in %s on %s: expected %h, actual %h", test_name, what, expected, actual);
		$display("TB FAILED");
		$fatal(1, "check failed");
	endtask

	// checked at the falling edge, well after inputs and outputs settle
	ready_check: assert property (@(negedge clk) disable iff (rst) dispatch_ready == exp_ready)
		else report_mismatch("dispatch_ready", 128'(exp_ready), 128'(dispatch_ready));
	tag0_check: assert property (@(negedge clk) disable iff (rst) alloc_tag0 == exp_tag0)
		else report_mismatch("alloc_tag0", 128'(exp_tag0), 128'(alloc_tag0));
	tag1_check: assert property (@(negedge clk) disable iff (rst) alloc_tag1 == exp_tag1)
		else report_mismatch("alloc_tag1", 128'(exp_tag1), 128'(alloc_tag1));
	// payload only matters while valid
	commit_check: assert property (@(negedge clk) disable iff (rst)
		commit.valid == exp_commit.valid && (!exp_commit.valid || commit == exp_commit))
		else report_mismatch("commit", 128'(exp_commit), 128'(commit));
	src0_check: assert property (@(negedge clk) disable iff (rst) !check_ops || src0 == exp_src0)
		else report_mismatch("src0", 128'(exp_src0), 128'(src0));
	src1_check: assert property (@(negedge clk) disable iff (rst) !check_ops || src1 == exp_src1)
		else report_mismatch("src1", 128'(exp_src1), 128'(src1));

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// upper bits of the LCG are the better mixed ones
	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = lcg_next();
		return int'(r[30:15]) % n;
	endfunction

	function automatic tomasulo_pkg::word_t fresh_data();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = lcg_next();
		lo = lcg_next();
		return {hi[31:16], lo[31:16]};
	endfunction

	function automatic tomasulo_pkg::dispatch_t random_dispatch();
		tomasulo_pkg::dispatch_t d;
		d.valid = 1'b1;
		d.rd = tomasulo_pkg::reg_idx_t'(rand_below(RD_SPAN));
		// roughly one in six is a branch or store
		d.has_dest = rand_below(6) != 0;
		return d;
	endfunction

	// youngest in-flight writer decides, otherwise the committed value
	function automatic tomasulo_pkg::operand_t model_read(input tomasulo_pkg::reg_idx_t idx);
		tomasulo_pkg::operand_t op;
		op.busy = 1'b0;
		op.value = arch_regs[idx];
		if (idx != '0) begin
			for (int i = 0; i < rob_q.size(); i++) begin
				if (rob_q[i].has_dest && rob_q[i].rd == idx) begin
					op.busy = !rob_q[i].ready;
					op.value = rob_q[i].ready ? rob_q[i].data : tomasulo_pkg::word_t'(rob_q[i].tag);
				end
			end
		end
		return op;
	endfunction

	// slot 1 sees the rename slot 0 makes in the same cycle
	function automatic tomasulo_pkg::operand_t slot1_read(input tomasulo_pkg::reg_idx_t idx,
		input logic rename0, input tomasulo_pkg::reg_idx_t rd0);
		tomasulo_pkg::operand_t op;
		op = model_read(idx);
		if (rename0 && idx == rd0) begin
			op.busy = 1'b1;
			op.value = tomasulo_pkg::word_t'(model_rear);
		end
		return op;
	endfunction

	task automatic push_entry(input tomasulo_pkg::dispatch_t d);
		model_entry_t ent;
		ent.tag = model_rear;
		ent.rd = d.rd;
		ent.has_dest = d.has_dest;
		ent.ready = 1'b0;
		ent.data = '0;
		rob_q.push_back(ent);
		model_rear = model_rear + TW'(1);
	endtask

	// applies the inputs that were present at this edge
	task automatic update_model();
		model_entry_t ent;
		logic         accept;
		int           keep;
		accept = rob_q.size() <= DEPTH - 2 && !mispredict && dispatch0.valid;
		if (rob_q.size() != 0 && rob_q[0].ready) begin
			ent = rob_q.pop_front();
			if (ent.has_dest && ent.rd != '0) begin
				arch_regs[ent.rd] = ent.data;
			end
		end
		if (cdb.valid) begin
			for (int i = 0; i < rob_q.size(); i++) begin
				if (rob_q[i].tag == cdb.tag) begin
					ent = rob_q[i];
					ent.ready = 1'b1;
					ent.data = cdb.data;
					rob_q[i] = ent;
				end
			end
		end
		if (mispredict) begin
			// branch may have retired at this very edge, then nothing survives
			keep = -1;
			for (int i = 0; i < rob_q.size(); i++) begin
				if (rob_q[i].tag == mispredict_tag) begin
					keep = i;
				end
			end
			while (rob_q.size() > keep + 1) begin
				ent = rob_q.pop_back();
			end
			model_rear = mispredict_tag + TW'(1);
		end else if (accept) begin
			push_entry(dispatch0);
			if (dispatch1.valid) begin
				push_entry(dispatch1);
			end
		end
	endtask

	// one clock: update the scoreboard, pick new stimulus, predict the outputs
	task automatic run_cycle(input int disp_pct, input int cdb_pct, input int mis_pct);
		tomasulo_pkg::dispatch_t nd0;
		tomasulo_pkg::dispatch_t nd1;
		tomasulo_pkg::cdb_t      ncdb;
		logic                    nmis;
		tomasulo_pkg::rob_tag_t  nmis_tag;
		tomasulo_pkg::reg_idx_t  ns [4];
		tomasulo_pkg::commit_t   ncommit;
		logic                    room;
		logic                    rename0;
		int                      pending [$];
		@(posedge clk);
		if (!rst) begin
			update_model();
		end
		nd0 = '0;
		nd1 = '0;
		ncdb = '0;
		nmis = 1'b0;
		nmis_tag = '0;
		ncommit = '0;
		room = rob_q.size() <= DEPTH - 2;
		// no mispredict while the previous one is still being rebuilt
		if (!mispredict && rob_q.size() != 0 && rand_below(100) < mis_pct) begin
			nmis = 1'b1;
			nmis_tag = rob_q[rand_below(rob_q.size())].tag;
		end else if (room && rand_below(100) < disp_pct) begin
			nd0 = random_dispatch();
			if (rand_below(2) == 1) begin
				nd1 = random_dispatch();
			end
		end
		// write-backs land in random order among the waiting entries
		for (int i = 0; i < rob_q.size(); i++) begin
			if (!rob_q[i].ready) begin
				pending.push_back(i);
			end
		end
		if (pending.size() != 0 && rand_below(100) < cdb_pct) begin
			ncdb.valid = 1'b1;
			ncdb.tag = rob_q[pending[rand_below(pending.size())]].tag;
			ncdb.data = fresh_data();
		end
		for (int i = 0; i < 4; i++) begin
			ns[i] = tomasulo_pkg::reg_idx_t'(rand_below(SRC_SPAN));
		end
		if (nd0.valid && rand_below(3) == 0) begin
			ns[2] = nd0.rd;
		end
		if (rob_q.size() != 0 && rob_q[0].ready) begin
			ncommit.valid = 1'b1;
			ncommit.rd = rob_q[0].has_dest ? rob_q[0].rd : '0;
			ncommit.data = rob_q[0].data;
			ncommit.tag = rob_q[0].tag;
		end
		rename0 = room && nd0.valid && nd0.has_dest && nd0.rd != '0;
		dispatch0 <= nd0;
		dispatch1 <= nd1;
		cdb <= ncdb;
		mispredict <= nmis;
		mispredict_tag <= nmis_tag;
		rs1_0 <= ns[0];
		rs2_0 <= ns[1];
		rs1_1 <= ns[2];
		rs2_1 <= ns[3];
		exp_ready <= room;
		exp_tag0 <= model_rear;
		exp_tag1 <= model_rear + TW'(1);
		exp_commit <= ncommit;
		exp_src0 <= {model_read(ns[0]), model_read(ns[1])};
		exp_src1 <= {slot1_read(ns[2], rename0, nd0.rd), slot1_read(ns[3], rename0, nd0.rd)};
		check_ops <= !mispredict;
	endtask

	initial begin
		for (int r = 0; r < NREGS; r++) begin
			arch_regs[r] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		test_name = "reset_state";
		repeat (IDLE_CYCLES) run_cycle(0, 0, 0);
		for (int c = 0; c < RANDOM_CYCLES; c++) begin
			// every third block of 100 cycles starves write-back so the ROB fills up
			if ((c / 100) % 3 == 2) begin
				test_name = "backpressure";
				run_cycle(90, 0, 0);
			end else begin
				test_name = "random_rename";
				run_cycle(60, 60, 3);
			end
		end
		test_name = "drain";
		while (rob_q.size() != 0) begin
			run_cycle(0, 100, 0);
		end
		repeat (4) run_cycle(0, 0, 0);
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: common/tomasulo_config.svh
`ifndef TOMASULO_CONFIG_SVH
`define TOMASULO_CONFIG_SVH

// width of every data word carried by the core
`define TOMA_XLEN 32

// architectural registers, x0 included
`define TOMA_NUM_REGS 32

// reorder buffer entries
// must stay a power of two so the tags wrap for free
`define TOMA_ROB_DEPTH 8

// log2 of the ROB depth
// one tag addresses exactly one ROB slot
`define TOMA_TAG_W 3

`endif

// File: common/tomasulo_pkg.sv
`default_nettype none

`include "tomasulo_config.svh"

package tomasulo_pkg;

	// architectural register number
	typedef logic [4:0] reg_idx_t;

	// ROB slot index, doubles as the rename tag
	typedef logic [`TOMA_TAG_W-1:0] rob_tag_t;

	// one data word
	typedef logic [`TOMA_XLEN-1:0] word_t;

	// one instruction entering rename
	// has_dest is low for branches and stores
	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		logic     has_dest;
	} dispatch_t;

	// result broadcast on the common data bus
	typedef struct packed {
		logic     valid;
		rob_tag_t tag;
		word_t    data;
	} cdb_t;

	// one reorder buffer slot
	typedef struct packed {
		logic     occupied;
		logic     ready;
		reg_idx_t rd;
		logic     has_dest;
		word_t    data;
	} rob_entry_t;

	// whole ROB as seen by the register file
	typedef rob_entry_t [`TOMA_ROB_DEPTH-1:0] rob_entries_t;

	// queue pointers, count is one bit wider to tell full from empty
	typedef struct packed {
		rob_tag_t               front;
		rob_tag_t               rear;
		logic [`TOMA_TAG_W:0]   count;
	} rob_ptrs_t;

	// one retiring instruction
	typedef struct packed {
		logic     valid;
		reg_idx_t rd;
		word_t    data;
		rob_tag_t tag;
	} commit_t;

	// registered mispredict, entries front..keep_tag survive
	typedef struct packed {
		logic     valid;
		rob_tag_t keep_tag;
	} flush_t;

	// source operand, value is a tag while busy
	typedef struct packed {
		logic  busy;
		word_t value;
	} operand_t;

	// both sources of one issue slot
	typedef struct packed {
		operand_t r1;
		operand_t r2;
	} src_read_t;

endpackage

`default_nettype wire

// File: flist.f
+incdir+common
common/tomasulo_pkg.sv
rob/rob.sv
regfile/regfile.sv
hw/rename_top.sv
bench/tb_rename_top.sv

// File: hw/rename_top.sv
`default_nettype none

module rename_top (
	input  wire logic                      clk,
	input  wire logic                      rst,
	input  wire tomasulo_pkg::dispatch_t   dispatch0,
	input  wire tomasulo_pkg::dispatch_t   dispatch1,
	input  wire tomasulo_pkg::reg_idx_t    rs1_0,
	input  wire tomasulo_pkg::reg_idx_t    rs2_0,
	input  wire tomasulo_pkg::reg_idx_t    rs1_1,
	input  wire tomasulo_pkg::reg_idx_t    rs2_1,
	input  wire tomasulo_pkg::cdb_t        cdb,
	input  wire logic                      mispredict,
	input  wire tomasulo_pkg::rob_tag_t    mispredict_tag,
	output logic                           dispatch_ready,
	output tomasulo_pkg::rob_tag_t         alloc_tag0,
	output tomasulo_pkg::rob_tag_t         alloc_tag1,
	output tomasulo_pkg::src_read_t        src0,
	output tomasulo_pkg::src_read_t        src1,
	output tomasulo_pkg::commit_t          commit
);
	// ROB state the register file bypasses from and rebuilds from
	tomasulo_pkg::rob_entries_t entries;
	tomasulo_pkg::rob_ptrs_t    ptrs;
	tomasulo_pkg::flush_t       flush;

	rob u_rob (
		.clk            (clk),
		.rst            (rst),
		.dispatch0      (dispatch0),
		.dispatch1      (dispatch1),
		.cdb            (cdb),
		.mispredict     (mispredict),
		.mispredict_tag (mispredict_tag),
		.dispatch_ready (dispatch_ready),
		.alloc_tag0     (alloc_tag0),
		.alloc_tag1     (alloc_tag1),
		.entries        (entries),
		.ptrs           (ptrs),
		.flush          (flush),
		.commit         (commit)
	);

	// commit goes both out and into the architectural state
	regfile u_regfile (
		.clk        (clk),
		.rst        (rst),
		.entries    (entries),
		.ptrs       (ptrs),
		.flush      (flush),
		.commit     (commit),
		.dispatch0  (dispatch0),
		.dispatch1  (dispatch1),
		.alloc_tag0 (alloc_tag0),
		.alloc_tag1 (alloc_tag1),
		.rs1_0      (rs1_0),
		.rs2_0      (rs2_0),
		.rs1_1      (rs1_1),
		.rs2_1      (rs2_1),
		.src0       (src0),
		.src1       (src1)
	);

endmodule

`default_nettype wire

// File: regfile/regfile.sv
`default_nettype none

`include "tomasulo_config.svh"

module regfile (
	input  wire logic                      clk,
	input  wire logic                      rst,
	input  wire tomasulo_pkg::rob_entries_t entries,
	input  wire tomasulo_pkg::rob_ptrs_t   ptrs,
	input  wire tomasulo_pkg::flush_t      flush,
	input  wire tomasulo_pkg::commit_t     commit,
	input  wire tomasulo_pkg::dispatch_t   dispatch0,
	input  wire tomasulo_pkg::dispatch_t   dispatch1,
	input  wire tomasulo_pkg::rob_tag_t    alloc_tag0,
	input  wire tomasulo_pkg::rob_tag_t    alloc_tag1,
	input  wire tomasulo_pkg::reg_idx_t    rs1_0,
	input  wire tomasulo_pkg::reg_idx_t    rs2_0,
	input  wire tomasulo_pkg::reg_idx_t    rs1_1,
	input  wire tomasulo_pkg::reg_idx_t    rs2_1,
	output tomasulo_pkg::src_read_t        src0,
	output tomasulo_pkg::src_read_t        src1
);
	localparam int NREGS = `TOMA_NUM_REGS;
	localparam int DEPTH = `TOMA_ROB_DEPTH;
	localparam int XLEN  = `TOMA_XLEN;
	localparam int TW    = `TOMA_TAG_W;

	// committed value plus rename status of one register
	typedef struct packed {
		logic                   busy;
		tomasulo_pkg::rob_tag_t tag;
		tomasulo_pkg::word_t    value;
	} reg_state_t;

	reg_state_t regs [NREGS];

	// ROB only takes a dispatch when a pair of slots is free
	logic accept;
	logic rename0;
	logic rename1;

	// busy/tag map recomputed from the surviving ROB entries
	logic [NREGS-1:0]       rb_busy;
	tomasulo_pkg::rob_tag_t rb_tag [NREGS];

	// tag carried in the low bits of an operand value
	function automatic tomasulo_pkg::word_t tag_word(input tomasulo_pkg::rob_tag_t tag);
		return {{(XLEN-TW){1'b0}}, tag};
	endfunction

	// plain lookup against the registered state
	function automatic tomasulo_pkg::operand_t lookup(input tomasulo_pkg::reg_idx_t idx);
		tomasulo_pkg::operand_t   op;
		reg_state_t               st;
		tomasulo_pkg::rob_entry_t ent;
		st = regs[idx];
		ent = entries[st.tag];
		op.busy = 1'b0;
		op.value = st.value;
		if (idx != '0 && st.busy) begin
			if (ent.ready) begin
				// producer already wrote back, hand out its result
				op.value = ent.data;
			end else begin
				op.busy = 1'b1;
				op.value = tag_word(st.tag);
			end
		end
		return op;
	endfunction

	// slot 1 also sees the rename slot 0 makes this cycle
	function automatic tomasulo_pkg::operand_t lookup_slot1(input tomasulo_pkg::reg_idx_t idx);
		tomasulo_pkg::operand_t op;
		op = lookup(idx);
		if (rename0 && idx == dispatch0.rd) begin
			op.busy = 1'b1;
			op.value = tag_word(alloc_tag0);
		end
		return op;
	endfunction

	always_comb begin
		accept = int'(ptrs.count) <= DEPTH - 2;
		// x0 never renames, neither do branches and stores
		rename0 = accept && dispatch0.valid && dispatch0.has_dest && dispatch0.rd != '0;
		rename1 = accept && dispatch0.valid && dispatch1.valid && dispatch1.has_dest
			&& dispatch1.rd != '0;

		src0.r1 = lookup(rs1_0);
		src0.r2 = lookup(rs2_0);
		src1.r1 = lookup_slot1(rs1_1);
		src1.r2 = lookup_slot1(rs2_1);
	end

	// walk front to rear so the youngest writer of each rd wins
	always_comb begin
		for (int r = 0; r < NREGS; r++) begin
			rb_busy[r] = 1'b0;
			rb_tag[r] = '0;
		end
		for (int k = 0; k < DEPTH; k++) begin : walk
			tomasulo_pkg::rob_tag_t   idx;
			tomasulo_pkg::rob_entry_t ent;
			idx = ptrs.front + TW'(k);
			ent = entries[idx];
			// the head retiring this edge no longer holds its register
			if (k < int'(ptrs.count) && ent.occupied && ent.has_dest && ent.rd != '0
				&& !(commit.valid && commit.tag == idx)) begin
				rb_busy[ent.rd] = 1'b1;
				rb_tag[ent.rd] = idx;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < NREGS; r++) begin
				regs[r] <= '0;
			end
		end else begin
			// retirement always lands the value
			if (commit.valid && commit.rd != '0) begin
				regs[commit.rd].value <= commit.data;
				// a younger writer keeps the register busy
				if (regs[commit.rd].tag == commit.tag) begin
					regs[commit.rd].busy <= 1'b0;
				end
			end

			// recovery overrides whatever busy/tag said before
			if (flush.valid) begin
				for (int r = 1; r < NREGS; r++) begin
					regs[r].busy <= rb_busy[r];
					regs[r].tag <= rb_tag[r];
				end
			end

			// renames are younger than anything above
			if (rename0) begin
				regs[dispatch0.rd].busy <= 1'b1;
				regs[dispatch0.rd].tag <= alloc_tag0;
			end
			// slot 1 last, it wins a shared rd
			if (rename1) begin
				regs[dispatch1.rd].busy <= 1'b1;
				regs[dispatch1.rd].tag <= alloc_tag1;
			end
		end
	end

endmodule

`default_nettype wire

// File: rob/rob.sv
`default_nettype none

`include "tomasulo_config.svh"

module rob (
	input  wire logic                      clk,
	input  wire logic                      rst,
	input  wire tomasulo_pkg::dispatch_t   dispatch0,
	input  wire tomasulo_pkg::dispatch_t   dispatch1,
	input  wire tomasulo_pkg::cdb_t        cdb,
	input  wire logic                      mispredict,
	input  wire tomasulo_pkg::rob_tag_t    mispredict_tag,
	output logic                           dispatch_ready,
	output tomasulo_pkg::rob_tag_t         alloc_tag0,
	output tomasulo_pkg::rob_tag_t         alloc_tag1,
	output tomasulo_pkg::rob_entries_t     entries,
	output tomasulo_pkg::rob_ptrs_t        ptrs,
	output tomasulo_pkg::flush_t           flush,
	output tomasulo_pkg::commit_t          commit
);
	localparam int DEPTH = `TOMA_ROB_DEPTH;
	localparam int TW    = `TOMA_TAG_W;

	// head, next free slot and occupancy
	tomasulo_pkg::rob_tag_t front;
	tomasulo_pkg::rob_tag_t rear;
	logic [TW:0]            count;

	logic                   alloc0;
	logic                   alloc1;
	logic [TW:0]            n_alloc;
	logic                   commit_fire;
	// occupancy right after truncation, before any retirement
	logic [TW:0]            keep_count;
	// one bit per slot thrown away by this cycle's mispredict
	logic [DEPTH-1:0]       discard;

	// true when idx lies in the circular window head..last
	function automatic logic survives(
		input tomasulo_pkg::rob_tag_t idx,
		input tomasulo_pkg::rob_tag_t head,
		input tomasulo_pkg::rob_tag_t last
	);
		tomasulo_pkg::rob_tag_t off_idx;
		tomasulo_pkg::rob_tag_t off_last;
		// distances from the head wrap with the tag width
		off_idx  = idx - head;
		off_last = last - head;
		return off_idx <= off_last;
	endfunction

	always_comb begin
		// room for a full pair keeps the dispatch logic simple
		dispatch_ready = int'(count) <= DEPTH - 2;

		// slot 1 always lands right behind slot 0
		alloc_tag0 = rear;
		alloc_tag1 = rear + TW'(1);

		// a dispatch during a mispredict belongs to the wrong path
		alloc0 = dispatch_ready && !mispredict && dispatch0.valid;
		alloc1 = alloc0 && dispatch1.valid;
		n_alloc = (TW+1)'(alloc0) + (TW+1)'(alloc1);

		// retire straight from the head, one per cycle
		commit_fire = entries[front].occupied && entries[front].ready;
		commit.valid = commit_fire;
		// branches and stores retire with x0 so nothing gets written
		commit.rd = entries[front].has_dest ? entries[front].rd : '0;
		commit.data = entries[front].data;
		commit.tag = front;

		// the branch itself stays, so add one
		keep_count = (TW+1)'(tomasulo_pkg::rob_tag_t'(mispredict_tag - front)) + (TW+1)'(1);

		for (int i = 0; i < DEPTH; i++) begin
			discard[i] = mispredict && !survives(TW'(i), front, mispredict_tag);
		end

		ptrs.front = front;
		ptrs.rear  = rear;
		ptrs.count = count;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			front <= '0;
			rear <= '0;
			count <= '0;
			flush.valid <= 1'b0;
			// payload fields of the slots stay as they are
			for (int i = 0; i < DEPTH; i++) begin
				entries[i].occupied <= 1'b0;
				entries[i].ready <= 1'b0;
			end
		end else begin
			// regfile rebuilds one edge later from the truncated queue
			flush.valid <= mispredict;
			flush.keep_tag <= mispredict_tag;

			front <= front + TW'(commit_fire);

			if (mispredict) begin
				// rear snaps to just past the branch
				rear <= mispredict_tag + TW'(1);
				count <= keep_count - (TW+1)'(commit_fire);
			end else begin
				rear <= rear + TW'(n_alloc);
				count <= count + n_alloc - (TW+1)'(commit_fire);
			end

			// write-back, ignored for free or discarded slots
			if (cdb.valid && entries[cdb.tag].occupied && !discard[cdb.tag]) begin
				entries[cdb.tag].ready <= 1'b1;
				entries[cdb.tag].data <= cdb.data;
			end

			// allocation into the free tail
			if (alloc0) begin
				entries[alloc_tag0].occupied <= 1'b1;
				entries[alloc_tag0].ready <= 1'b0;
				entries[alloc_tag0].rd <= dispatch0.rd;
				entries[alloc_tag0].has_dest <= dispatch0.has_dest;
			end
			if (alloc1) begin
				entries[alloc_tag1].occupied <= 1'b1;
				entries[alloc_tag1].ready <= 1'b0;
				entries[alloc_tag1].rd <= dispatch1.rd;
				entries[alloc_tag1].has_dest <= dispatch1.has_dest;
			end

			// head slot frees on retirement
			if (commit_fire) begin
				entries[front].occupied <= 1'b0;
				entries[front].ready <= 1'b0;
			end

			// wrong-path slots vanish in the same edge
			for (int i = 0; i < DEPTH; i++) begin
				if (discard[i]) begin
					entries[i].occupied <= 1'b0;
					entries[i].ready <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build the rename slice with Verilator and run its testbench

cd "$(dirname "$0")" || exit 1

log=sim.log
build_dir=obj_dir

verilator --binary --assert --top-module tb_rename_top \
	--Mdir "$build_dir" -o tb_rename_top -f flist.f
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

"./$build_dir/tb_rename_top" > "$log" 2>&1
run_status=$?
cat "$log"

# verdict comes from the log
if grep -q "TB FAILED" "$log"; then
	echo "simulation reported a failure, see $log"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

echo "simulation finished without failures"
exit 0
